/* design/phit_cfg.svh */
`ifndef PHIT_CFG_SVH
`define PHIT_CFG_SVH

// fraction bits of every fixed-point word.
`define PHIT_Q_BITS 10

// width of one vector component.
`define PHIT_FIX_W 32

// words held by each vector fifo.
`define PHIT_FIFO_DEPTH 16

`endif

/* design/fixed_pkg.sv */
`default_nettype none

`include "phit_cfg.svh"

package fixed_pkg;

    // signed q-format scalar, used for t and for every component.
    typedef logic signed [`PHIT_FIX_W-1:0] fix_t;

    // full product of two scalars, before realignment.
    typedef logic signed [2*`PHIT_FIX_W-1:0] prod_t;

endpackage

`default_nettype wire

/* design/vec_pkg.sv */
`default_nettype none

package vec_pkg;
    import fixed_pkg::*;

    // three-component vector, x in the top bits.
    typedef struct packed {
        fix_t x;
        fix_t y;
        fix_t z;
    } vec3_t;

    // raw storage word of one vector.
    typedef logic [$bits(vec3_t)-1:0] vec_word_t;

endpackage

`default_nettype wire

/* design/vec_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

`include "phit_cfg.svh"

module vec_fifo
    import vec_pkg::*;
#(
    parameter int DEPTH = `PHIT_FIFO_DEPTH
) (
    input  logic  clock,
    input  logic  arst_n,
    input  logic  wr_en,
    input  vec3_t din,
    output logic  full,
    input  logic  rd_en,
    output vec3_t dout,
    output logic  empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    vec_word_t mem [DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;

    logic do_wr;
    logic do_rd;

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    assign full  = (count == cnt_t'(DEPTH));
    assign empty = (count == '0);

    // head word goes out without a register.
    assign dout = vec3_t'(mem[rd_ptr]);

    always_ff @(posedge clock) begin
        if (do_wr) begin
            mem[wr_ptr] <= vec_word_t'(din);
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the writer must watch full.
    a_no_wr_full : assert property (@(posedge clock) disable iff (!arst_n)
        !(wr_en && full))
        else $error("vec_fifo: write while full");

    // the reader must watch empty.
    a_no_rd_empty : assert property (@(posedge clock) disable iff (!arst_n)
        !(rd_en && empty))
        else $error("vec_fifo: read while empty");

endmodule

`default_nettype wire

/* design/vec_scale.sv */
`timescale 1ns/1ns
`default_nettype none

`include "phit_cfg.svh"

module vec_scale
    import fixed_pkg::*;
    import vec_pkg::*;
#(
    parameter int Q_BITS = `PHIT_Q_BITS
) (
    input  logic  clock,
    input  logic  arst_n,
    input  vec3_t x,
    input  fix_t  a,
    input  logic  in_empty,
    output logic  in_rd_en,
    output vec3_t out,
    output logic  out_empty,
    input  logic  out_rd_en
);

    logic  valid;
    logic  accept;
    vec3_t scaled;

    // full product, then arithmetic shift, so rounding is toward minus infinity.
    function automatic fix_t scale_comp(input fix_t v, input fix_t s);
        prod_t p;
        p = prod_t'(v) * prod_t'(s);
        return fix_t'(p >>> Q_BITS);
    endfunction

    assign scaled.x = scale_comp(x.x, a);
    assign scaled.y = scale_comp(x.y, a);
    assign scaled.z = scale_comp(x.z, a);

    // take a new word when the register is free or drains this cycle.
    assign accept   = !in_empty && (!valid || out_rd_en);
    assign in_rd_en = accept;

    assign out_empty = !valid;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid <= 1'b0;
        end else if (accept) begin
            valid <= 1'b1;
        end else if (out_rd_en) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            out <= scaled;
        end
    end

    // a held result must not move under the consumer.
    a_hold_stable : assert property (@(posedge clock) disable iff (!arst_n)
        (valid && !out_rd_en) |=> (valid && $stable(out)))
        else $error("vec_scale: output changed while held");

endmodule

`default_nettype wire

/* design/vec_add.sv */
`timescale 1ns/1ns
`default_nettype none

module vec_add
    import fixed_pkg::*;
    import vec_pkg::*;
(
    input  logic  clock,
    input  logic  arst_n,
    input  vec3_t x,
    input  vec3_t y,
    input  logic  in_empty,
    output logic  in_rd_en,
    output vec3_t out,
    output logic  out_empty,
    input  logic  out_rd_en
);

    logic  valid;
    logic  accept;
    vec3_t sum;

    // wraps at the component width.
    function automatic fix_t add_comp(input fix_t p, input fix_t q);
        return fix_t'(p + q);
    endfunction

    assign sum.x = add_comp(x.x, y.x);
    assign sum.y = add_comp(x.y, y.y);
    assign sum.z = add_comp(x.z, y.z);

    assign accept    = !in_empty && (!valid || out_rd_en);
    assign in_rd_en  = accept;
    assign out_empty = !valid;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid <= 1'b0;
        end else if (accept) begin
            valid <= 1'b1;
        end else if (out_rd_en) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            out <= sum;
        end
    end

    // p_hit holds steady until read.
    a_hold_stable : assert property (@(posedge clock) disable iff (!arst_n)
        (valid && !out_rd_en) |=> (valid && $stable(out)))
        else $error("vec_add: output changed while held");

endmodule

`default_nettype wire

/* design/p_hit_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "phit_cfg.svh"

module p_hit_unit
    import fixed_pkg::*;
    import vec_pkg::*;
(
    input  logic  clock,
    input  logic  arst_n,
    input  vec3_t dir,
    input  logic  dir_empty,
    input  vec3_t origin,
    input  logic  origin_empty,
    input  fix_t  t,
    input  logic  t_empty,
    output logic  dir_t_rd_en,
    output logic  origin_rd_en,
    output vec3_t p_hit,
    output logic  p_hit_empty,
    input  logic  p_hit_rd_en
);

    vec3_t scale_out;
    logic  scale_out_empty;
    logic  scale_in_empty;
    logic  add_in_empty;

    // direction and t pair up, as do scaled direction and origin.
    assign scale_in_empty = dir_empty || t_empty;
    assign add_in_empty   = scale_out_empty || origin_empty;

    vec_scale #(
        .Q_BITS    (`PHIT_Q_BITS)
    ) u_scale (
        .clock     (clock),
        .arst_n    (arst_n),
        .x         (dir),
        .a         (t),
        .in_empty  (scale_in_empty),
        .in_rd_en  (dir_t_rd_en),
        .out       (scale_out),
        .out_empty (scale_out_empty),
        .out_rd_en (origin_rd_en)
    );

    // one strobe pops the scale register and the origin fifo together.
    vec_add u_add (
        .clock     (clock),
        .arst_n    (arst_n),
        .x         (scale_out),
        .y         (origin),
        .in_empty  (add_in_empty),
        .in_rd_en  (origin_rd_en),
        .out       (p_hit),
        .out_empty (p_hit_empty),
        .out_rd_en (p_hit_rd_en)
    );

endmodule

`default_nettype wire

/* design/p_hit_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "phit_cfg.svh"

module p_hit_top
    import fixed_pkg::*;
    import vec_pkg::*;
(
    input  logic  clock,
    input  logic  arst_n,
    input  logic  dir_wr_en,
    input  vec3_t dir_in,
    output logic  dir_full,
    input  logic  origin_wr_en,
    input  vec3_t origin_in,
    output logic  origin_full,
    input  fix_t  t,
    input  logic  t_empty,
    output logic  t_rd_en,
    output vec3_t p_hit,
    output logic  p_hit_empty,
    input  logic  p_hit_rd_en
);

    vec3_t dir_out;
    vec3_t origin_out;
    logic  dir_empty;
    logic  origin_empty;
    logic  origin_rd_en;

    // t_rd_en also pops the direction fifo.
    vec_fifo #(
        .DEPTH  (`PHIT_FIFO_DEPTH)
    ) dir_fifo (
        .clock  (clock),
        .arst_n (arst_n),
        .wr_en  (dir_wr_en),
        .din    (dir_in),
        .full   (dir_full),
        .rd_en  (t_rd_en),
        .dout   (dir_out),
        .empty  (dir_empty)
    );

    vec_fifo #(
        .DEPTH  (`PHIT_FIFO_DEPTH)
    ) origin_fifo (
        .clock  (clock),
        .arst_n (arst_n),
        .wr_en  (origin_wr_en),
        .din    (origin_in),
        .full   (origin_full),
        .rd_en  (origin_rd_en),
        .dout   (origin_out),
        .empty  (origin_empty)
    );

    p_hit_unit u_p_hit_unit (
        .clock        (clock),
        .arst_n       (arst_n),
        .dir          (dir_out),
        .dir_empty    (dir_empty),
        .origin       (origin_out),
        .origin_empty (origin_empty),
        .t            (t),
        .t_empty      (t_empty),
        .dir_t_rd_en  (t_rd_en),
        .origin_rd_en (origin_rd_en),
        .p_hit        (p_hit),
        .p_hit_empty  (p_hit_empty),
        .p_hit_rd_en  (p_hit_rd_en)
    );

endmodule

`default_nettype wire

/* sim/p_hit_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "phit_cfg.svh"

module p_hit_tb
    import fixed_pkg::*;
    import vec_pkg::*;
;

    logic  clock = 1'b0;
    logic  arst_n = 1'b0;
    logic  dir_wr_en = 1'b0;
    vec3_t dir_in = '0;
    logic  dir_full;
    logic  origin_wr_en = 1'b0;
    vec3_t origin_in = '0;
    logic  origin_full;
    fix_t  t = '0;
    logic  t_empty = 1'b1;
    logic  t_rd_en;
    vec3_t p_hit;
    logic  p_hit_empty;
    logic  p_hit_rd_en = 1'b0;

    logic [31:0] lfsr_state = 32'd68774;
    vec3_t dir_pend[$];
    vec3_t origin_pend[$];
    fix_t  t_pend[$];
    vec3_t exp_q[$];
    bit    gaps = 1'b1;
    bit    stall = 1'b0;
    bit    hold_origin = 1'b0;
    bit    t_held = 1'b0;
    int    n_items = 0;
    int    n_results = 0;
    int    n_t_taken = 0;
    vec3_t held;

    p_hit_top p_hit_top_i (
        .clock        (clock),
        .arst_n       (arst_n),
        .dir_wr_en    (dir_wr_en),
        .dir_in       (dir_in),
        .dir_full     (dir_full),
        .origin_wr_en (origin_wr_en),
        .origin_in    (origin_in),
        .origin_full  (origin_full),
        .t            (t),
        .t_empty      (t_empty),
        .t_rd_en      (t_rd_en),
        .p_hit        (p_hit),
        .p_hit_empty  (p_hit_empty),
        .p_hit_rd_en  (p_hit_rd_en)
    );

    initial begin
        forever #20 clock = ~clock;
    end

    // galois lfsr, one step per bit.
    function automatic bit lfsr_bit();
        bit b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) lfsr_state = lfsr_state ^ 32'h8020_0003;
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) r = {r[30:0], lfsr_bit()};
        return r;
    endfunction

    // half the values small, half spanning the full word.
    function automatic fix_t rand_fix();
        logic [15:0] h;
        if (lfsr_bit()) return fix_t'(rand_bits(32));
        h = 16'(rand_bits(16));
        return fix_t'({{16{h[15]}}, h});
    endfunction

    function automatic bit gap_ok();
        return !gaps || lfsr_bit() || lfsr_bit();
    endfunction

    // o + floor(d * s / 2^q), wrapped to 32 bits.
    function automatic fix_t comp_ref(input fix_t d, input fix_t s, input fix_t o);
        longint p;
        p = longint'(d) * longint'(s);
        p = p >>> `PHIT_Q_BITS;
        return fix_t'(p[31:0] + o);
    endfunction

    function automatic vec3_t phit_ref(input vec3_t d, input fix_t s, input vec3_t o);
        vec3_t r;
        r.x = comp_ref(d.x, s, o.x);
        r.y = comp_ref(d.y, s, o.y);
        r.z = comp_ref(d.z, s, o.z);
        return r;
    endfunction

    task automatic fail_now();
        $display("TEST FAILED");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_vec(input vec3_t got, input vec3_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
            fail_now();
        end
    endtask

    task automatic check_flag(input bit got, input bit exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %0b, expected %0b", $time, what, got, exp);
            fail_now();
        end
    endtask

    task automatic push_item(input vec3_t d, input fix_t s, input vec3_t o);
        dir_pend.push_back(d);
        t_pend.push_back(s);
        origin_pend.push_back(o);
        exp_q.push_back(phit_ref(d, s, o));
        n_items++;
    endtask

    task automatic push_random(input int n);
        for (int i = 0; i < n; i++) begin
            push_item({rand_fix(), rand_fix(), rand_fix()}, rand_fix(),
                      {rand_fix(), rand_fix(), rand_fix()});
        end
    endtask

    task automatic wait_drained(input int limit);
        int cycles;
        cycles = 0;
        while (exp_q.size() > 0) begin
            @(posedge clock);
            cycles++;
            if (cycles > limit) begin
                $display("timeout: %0d results never came out", exp_q.size());
                fail_now();
            end
        end
        repeat (3) @(posedge clock);
    endtask

    task automatic wait_both_full(input int limit);
        int cycles;
        cycles = 0;
        while (!(dir_full && origin_full)) begin
            @(posedge clock);
            cycles++;
            if (cycles > limit) begin
                $display("timeout: input fifos never filled under a stalled consumer");
                fail_now();
            end
        end
    endtask

    // writers only issue when no write is in flight, so full is current.
    always @(posedge clock) begin
        if (arst_n && !dir_wr_en && !dir_full && dir_pend.size() > 0 && gap_ok()) begin
            dir_in    <= dir_pend.pop_front();
            dir_wr_en <= 1'b1;
        end else begin
            dir_wr_en <= 1'b0;
        end
    end

    always @(posedge clock) begin
        if (arst_n && !hold_origin && !origin_wr_en && !origin_full &&
            origin_pend.size() > 0 && gap_ok()) begin
            origin_in    <= origin_pend.pop_front();
            origin_wr_en <= 1'b1;
        end else begin
            origin_wr_en <= 1'b0;
        end
    end

    // t source, popped when the dut strobes t_rd_en.
    always @(posedge clock) begin
        if (arst_n) begin
            if (t_rd_en) begin
                t_held = 1'b0;
                n_t_taken++;
            end
            if (!t_held && t_pend.size() > 0 && gap_ok()) begin
                t      <= t_pend.pop_front();
                t_held = 1'b1;
            end
            t_empty <= !t_held;
        end
    end

    // monitor and scoreboard.
    always @(posedge clock) begin
        if (arst_n && !p_hit_rd_en && !p_hit_empty && !stall && gap_ok()) begin
            if (exp_q.size() == 0) begin
                $display("p_hit appeared with no matching input");
                fail_now();
            end
            check_vec(p_hit, exp_q.pop_front(), "p_hit");
            n_results++;
            p_hit_rd_en <= 1'b1;
        end else begin
            p_hit_rd_en <= 1'b0;
        end
    end

    initial begin
        repeat (10) @(posedge clock);
        arst_n <= 1'b1;
        @(posedge clock);
        check_flag(p_hit_empty, 1'b1, "p_hit_empty after reset");
        check_flag(dir_full, 1'b0, "dir_full after reset");
        check_flag(origin_full, 1'b0, "origin_full after reset");
        check_flag(t_rd_en, 1'b0, "t_rd_en after reset");

        // t = 1.0, t = 0 and a negative product at t = 0.5.
        push_item({32'sd1536, -32'sd2304, 32'sd7}, 32'sd1024, {32'sd100, -32'sd5, 32'sd0});
        push_item({32'sd1536, -32'sd2304, 32'sd7}, 32'sd0, {32'sd100, -32'sd5, 32'sd0});
        push_item({-32'sd3, -32'sd1, 32'sd3}, 32'sd512, '0);
        wait_drained(500);

        push_random(200);
        wait_drained(10000);

        stall = 1'b1;
        push_random(40);
        wait_both_full(2000);
        @(posedge clock);
        held = p_hit;
        check_flag(p_hit_empty, 1'b0, "p_hit_empty while stalled");
        repeat (20) begin
            @(posedge clock);
            check_vec(p_hit, held, "held p_hit");
        end
        stall = 1'b0;
        wait_drained(5000);

        // late origins hold back every result.
        hold_origin = 1'b1;
        push_random(5);
        repeat (30) begin
            @(posedge clock);
            check_flag(p_hit_empty, 1'b1, "p_hit_empty without origin");
        end
        hold_origin = 1'b0;
        wait_drained(2000);

        gaps = 1'b0;
        push_random(100);
        wait_drained(5000);
        if (n_results != n_items || n_t_taken != n_items) begin
            $display("Fail at %0t: %0d results and %0d t reads for %0d inputs",
                     $time, n_results, n_t_taken, n_items);
            fail_now();
        end
        check_flag(p_hit_empty, 1'b1, "p_hit_empty at end");

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* phit.f */
+incdir+design
design/fixed_pkg.sv
design/vec_pkg.sv
design/vec_fifo.sv
design/vec_scale.sv
design/vec_add.sv
design/p_hit_unit.sv
design/p_hit_top.sv
sim/p_hit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module p_hit_tb -f phit.f \
    --Mdir obj_dir -o p_hit_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/p_hit_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0
